/* source/icache_pkg.sv */
/*
  Instruction cache access port definitions
  Array geometry, entry layouts, requester structs and the grant vector
  shared by the arbiter, the array controls and the top level
*/

package icache_pkg;

  //======================================================================
  // Geometry
  //======================================================================
  localparam int INDEX_W   = 6;
  localparam int TAG_W     = 28;
  localparam int INST_W    = 128;
  localparam int PRECODE_W = 32;
  localparam int NUM_WAYS  = 2;

  typedef logic [INDEX_W-1:0] index_t;

  //======================================================================
  // Array entries
  //======================================================================
  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic [INST_W-1:0]    inst;
    logic [PRECODE_W-1:0] precode;
  } line_t;

  // Fifo bit on top, then way 1, then way 0
  typedef struct packed {
    logic       fifo;
    tag_entry_t way1;
    tag_entry_t way0;
  } tag_dout_t;

  //======================================================================
  // Requests
  //======================================================================
  typedef struct packed {
    logic                valid;
    index_t              index;
    logic [NUM_WAYS-1:0] way_pred;
  } fetch_req_t;

  typedef struct packed {
    logic                 wr;
    logic                 first;
    logic                 last;
    logic                 fifo;
    index_t               index;
    logic [TAG_W-1:0]     ptag;
    logic [INST_W-1:0]    inst;
    logic [PRECODE_W-1:0] precode;
  } refill_req_t;

  // Write mask bits are fifo, way1, way0
  typedef struct packed {
    logic       valid;
    index_t     index;
    logic [2:0] wmask;
    logic       fifo;
  } inv_req_t;

  typedef struct packed {
    logic   valid;
    index_t index;
  } ipb_req_t;

  typedef struct packed {
    logic inv;
    logic refill;
    logic ipb;
    logic fetch;
  } grant_t;

endpackage

/* source/icache_sram.sv */
/*
  Single port synchronous array
  Registered read, write-through disabled, dout held when idle
*/

`timescale 1ns/10ps

module icache_sram #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 1 << icache_pkg::INDEX_W
) (
  input  logic               hpcp_clk,
  input  logic               cpurst_b,
  input  logic               cen,
  input  logic               wen,
  input  icache_pkg::index_t index,
  input  entry_t             din,
  output entry_t             dout
);

  entry_t mem [DEPTH];

  //======================================================================
  // Array and read register
  //======================================================================
  always_ff @(posedge hpcp_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= '0;
      dout <= '0;
    end
    else if (cen)
    begin
      // A write leaves dout as it was
      if (wen)
        mem[index] <= din;
      else
        dout <= mem[index];
    end
  end

endmodule

/* source/icache_index_arb.sv */
/*
  Instruction cache index arbiter
  Fixed priority grant over invalidate, refill, prefetch and fetch,
  shared index mux, and the registered access and miss events
*/

`timescale 1ns/10ps

module icache_index_arb (
  input  logic                    hpcp_clk,
  input  logic                    cpurst_b,
  input  logic                    icache_en,
  input  logic                    cnt_en,
  input  logic                    miss_pre,
  input  icache_pkg::inv_req_t    inv_req,
  input  icache_pkg::refill_req_t refill_req,
  input  icache_pkg::ipb_req_t    ipb_req,
  input  icache_pkg::fetch_req_t  fetch_req,
  output icache_pkg::grant_t      grant,
  output icache_pkg::index_t      index,
  output logic                    hpcp_access,
  output logic                    hpcp_miss
);

  import icache_pkg::*;

  logic inv_act;
  logic refill_act;
  logic ipb_act;
  logic fetch_act;
  logic access_pre;
  logic cnt_upd;

  //======================================================================
  // Request qualification and grant
  //======================================================================
  // Invalidate still runs with the cache off
  assign inv_act    = inv_req.valid;
  assign refill_act = refill_req.wr && icache_en;
  assign ipb_act    = ipb_req.valid && icache_en;
  assign fetch_act  = fetch_req.valid && icache_en;

  always_comb
  begin
    grant = '0;
    if (inv_act)
      grant.inv = 1'b1;
    else if (refill_act)
      grant.refill = 1'b1;
    else if (ipb_act)
      grant.ipb = 1'b1;
    else if (fetch_act)
      grant.fetch = 1'b1;
  end

  // One-hot grant, so an AND-OR mux is enough
  assign index = ({INDEX_W{grant.inv}}    & inv_req.index)
               | ({INDEX_W{grant.refill}} & refill_req.index)
               | ({INDEX_W{grant.ipb}}    & ipb_req.index)
               | ({INDEX_W{grant.fetch}}  & fetch_req.index);

  //======================================================================
  // Performance events
  //======================================================================
  assign access_pre = fetch_req.valid && icache_en;
  assign cnt_upd    = icache_en && cnt_en;

  always_ff @(posedge hpcp_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      hpcp_access <= 1'b0;
      hpcp_miss   <= 1'b0;
    end
    else if (cnt_upd)
    begin
      hpcp_access <= access_pre;
      hpcp_miss   <= miss_pre;
    end
  end

  // Arrays see at most one requester per cycle
  a_grant_onehot: assert property (
    @(posedge hpcp_clk) disable iff (!cpurst_b) $onehot0(grant));

  // Counters frozen while counting is off
  a_event_hold: assert property (
    @(posedge hpcp_clk) disable iff (!cpurst_b)
    !cnt_upd |=> $stable({hpcp_access, hpcp_miss}));

endmodule

/* source/icache_tag_ctrl.sv */
/*
  Instruction cache tag array control
  Enables, write enables and write data for both tag ways and the
  fifo store, following the fifo replacement rule on refill
*/

`timescale 1ns/10ps

module icache_tag_ctrl (
  input  icache_pkg::grant_t                 grant,
  input  icache_pkg::inv_req_t               inv_req,
  input  icache_pkg::refill_req_t            refill_req,
  output logic [icache_pkg::NUM_WAYS-1:0]    tag_cen,
  output logic [icache_pkg::NUM_WAYS-1:0]    tag_wen,
  output icache_pkg::tag_entry_t             tag_din,
  output logic                               fifo_cen,
  output logic                               fifo_wen,
  output logic                               fifo_din
);

  import icache_pkg::*;

  logic                any_grant;
  logic                refill_tag_wr;
  logic [NUM_WAYS-1:0] fifo_way;

  // Tags are read or written on every granted access
  assign any_grant = |grant;
  assign tag_cen   = {NUM_WAYS{any_grant}};
  assign fifo_cen  = any_grant;

  // Only first and last beats touch the tag store
  assign refill_tag_wr = grant.refill && (refill_req.first || refill_req.last);
  assign fifo_way      = {refill_req.fifo, ~refill_req.fifo};

  always_comb
  begin
    tag_wen  = '0;
    tag_din  = '0;
    fifo_wen = 1'b0;
    fifo_din = 1'b0;
    if (grant.inv)
    begin
      tag_wen  = inv_req.wmask[1:0];
      fifo_wen = inv_req.wmask[2];
      fifo_din = inv_req.fifo;
    end
    else if (refill_tag_wr)
    begin
      tag_wen = fifo_way;
      // First beat clears the entry, last beat makes it valid
      tag_din.valid = refill_req.last;
      tag_din.tag   = refill_req.last ? refill_req.ptag : '0;
      fifo_wen      = refill_req.last;
      fifo_din      = ~refill_req.fifo;
    end
    if (refill_req.wr)
      a_first_last: assert final (!(refill_req.first && refill_req.last));
  end

endmodule

/* source/icache_data_ctrl.sv */
/*
  Instruction cache data array control
  Refill beats write the fifo-named way, fetches read the predicted ways
*/

`timescale 1ns/10ps

module icache_data_ctrl (
  input  icache_pkg::grant_t              grant,
  input  icache_pkg::fetch_req_t          fetch_req,
  input  icache_pkg::refill_req_t         refill_req,
  output logic [icache_pkg::NUM_WAYS-1:0] data_cen,
  output logic [icache_pkg::NUM_WAYS-1:0] data_wen,
  output icache_pkg::line_t               data_din
);

  import icache_pkg::*;

  logic [NUM_WAYS-1:0] fifo_way;

  assign fifo_way = {refill_req.fifo, ~refill_req.fifo};

  // Every refill beat carries a data and predecode word
  assign data_din.inst    = refill_req.inst;
  assign data_din.precode = refill_req.precode;

  always_comb
  begin
    data_cen = '0;
    data_wen = '0;
    if (grant.refill)
    begin
      data_cen = fifo_way;
      data_wen = fifo_way;
    end
    else if (grant.fetch)
      data_cen = fetch_req.way_pred;
    a_one_way_wr: assert final (!(data_wen[0] && data_wen[1]));
  end

endmodule

/* source/icache_if.sv */
/*
  Instruction cache access port
  Arbitrates four requesters onto the shared index and drives the
  two tag ways, the fifo store and the two data ways
*/

`timescale 1ns/10ps

module icache_if (
  input  logic                    hpcp_clk,
  input  logic                    cpurst_b,
  input  icache_pkg::inv_req_t    inv_req,
  input  icache_pkg::refill_req_t refill_req,
  input  icache_pkg::ipb_req_t    ipb_req,
  input  icache_pkg::fetch_req_t  fetch_req,
  input  logic                    icache_en,
  input  logic                    cnt_en,
  input  logic                    miss_pre,
  output icache_pkg::tag_dout_t   tag_dout,
  output icache_pkg::line_t       data_dout0,
  output icache_pkg::line_t       data_dout1,
  output logic                    hpcp_access,
  output logic                    hpcp_miss
);

  import icache_pkg::*;

  grant_t              grant;
  index_t              index;
  logic [NUM_WAYS-1:0] tag_cen;
  logic [NUM_WAYS-1:0] tag_wen;
  tag_entry_t          tag_din;
  tag_entry_t          tag_q0;
  tag_entry_t          tag_q1;
  logic                fifo_cen;
  logic                fifo_wen;
  logic                fifo_din;
  logic                fifo_q;
  logic [NUM_WAYS-1:0] data_cen;
  logic [NUM_WAYS-1:0] data_wen;
  line_t               data_din;

  //======================================================================
  // Arbitration and array control
  //======================================================================
  icache_index_arb u_index_arb (
    .hpcp_clk    (hpcp_clk),
    .cpurst_b    (cpurst_b),
    .icache_en   (icache_en),
    .cnt_en      (cnt_en),
    .miss_pre    (miss_pre),
    .inv_req     (inv_req),
    .refill_req  (refill_req),
    .ipb_req     (ipb_req),
    .fetch_req   (fetch_req),
    .grant       (grant),
    .index       (index),
    .hpcp_access (hpcp_access),
    .hpcp_miss   (hpcp_miss)
  );

  icache_tag_ctrl u_tag_ctrl (
    .grant      (grant),
    .inv_req    (inv_req),
    .refill_req (refill_req),
    .tag_cen    (tag_cen),
    .tag_wen    (tag_wen),
    .tag_din    (tag_din),
    .fifo_cen   (fifo_cen),
    .fifo_wen   (fifo_wen),
    .fifo_din   (fifo_din)
  );

  icache_data_ctrl u_data_ctrl (
    .grant      (grant),
    .fetch_req  (fetch_req),
    .refill_req (refill_req),
    .data_cen   (data_cen),
    .data_wen   (data_wen),
    .data_din   (data_din)
  );

  //======================================================================
  // Arrays
  //======================================================================
  // Tag ways share the write data, each has its own enables
  icache_sram #(.entry_t(tag_entry_t)) u_tag_way0 (
    .hpcp_clk (hpcp_clk),
    .cpurst_b (cpurst_b),
    .cen      (tag_cen[0]),
    .wen      (tag_wen[0]),
    .index    (index),
    .din      (tag_din),
    .dout     (tag_q0)
  );

  icache_sram #(.entry_t(tag_entry_t)) u_tag_way1 (
    .hpcp_clk (hpcp_clk),
    .cpurst_b (cpurst_b),
    .cen      (tag_cen[1]),
    .wen      (tag_wen[1]),
    .index    (index),
    .din      (tag_din),
    .dout     (tag_q1)
  );

  icache_sram #(.entry_t(logic)) u_fifo (
    .hpcp_clk (hpcp_clk),
    .cpurst_b (cpurst_b),
    .cen      (fifo_cen),
    .wen      (fifo_wen),
    .index    (index),
    .din      (fifo_din),
    .dout     (fifo_q)
  );

  icache_sram #(.entry_t(line_t)) u_data_way0 (
    .hpcp_clk (hpcp_clk),
    .cpurst_b (cpurst_b),
    .cen      (data_cen[0]),
    .wen      (data_wen[0]),
    .index    (index),
    .din      (data_din),
    .dout     (data_dout0)
  );

  icache_sram #(.entry_t(line_t)) u_data_way1 (
    .hpcp_clk (hpcp_clk),
    .cpurst_b (cpurst_b),
    .cen      (data_cen[1]),
    .wen      (data_wen[1]),
    .index    (index),
    .din      (data_din),
    .dout     (data_dout1)
  );

  // Tag read bundle
  assign tag_dout = '{fifo: fifo_q, way1: tag_q1, way0: tag_q0};

endmodule

/* tests/tb_icache_table.svh */
/*
  Stimulus table and array reference model for the access port testbench
  Shadow tag, fifo and data arrays track what every row should return
*/

`ifndef TB_ICACHE_TABLE_SVH
`define TB_ICACHE_TABLE_SVH

typedef struct packed {
  inv_req_t    inv;
  refill_req_t refill;
  ipb_req_t    ipb;
  fetch_req_t  fetch;
  logic        icache_en;
  logic        cnt_en;
  logic        miss_pre;
} stim_t;

// Same bit order as the DUT outputs laid end to end
typedef struct packed {
  tag_dout_t tag;
  line_t     d0;
  line_t     d1;
  logic      access;
  logic      miss;
} expect_t;

stim_t   stim_q [$];
expect_t exp_q [$];
logic    chk_q [$];
string   name_q [$];

// Shadow arrays and read registers start clear as after reset
tag_entry_t sh_tag [NUM_WAYS][1 << INDEX_W] = '{default: '0};
line_t      sh_data [NUM_WAYS][1 << INDEX_W] = '{default: '0};
logic       sh_fifo [1 << INDEX_W] = '{default: 1'b0};
tag_entry_t q_tag [NUM_WAYS] = '{default: '0};
line_t      q_data [NUM_WAYS] = '{default: '0};
logic       q_fifo = 1'b0;
logic       q_acc = 1'b0;
logic       q_miss = 1'b0;

//======================================================================
// Reference model stepped once per clock edge
//======================================================================
task automatic model_step(input stim_t s);
  logic       ref_a;
  logic       look_a;
  index_t     ix;
  tag_entry_t e;
  ref_a  = s.refill.wr && s.icache_en;
  look_a = (s.ipb.valid || s.fetch.valid) && s.icache_en;
  if (s.inv.valid)
  begin
    ix = s.inv.index;
    for (int w = 0; w < NUM_WAYS; w++)
      if (s.inv.wmask[w])
        sh_tag[w][ix] = '0;
      else
        q_tag[w] = sh_tag[w][ix];
    if (s.inv.wmask[2])
      sh_fifo[ix] = s.inv.fifo;
    else
      q_fifo = sh_fifo[ix];
  end
  else if (ref_a)
  begin
    ix = s.refill.index;
    e  = '0;
    if (s.refill.last)
    begin
      e.valid = 1'b1;
      e.tag   = s.refill.ptag;
    end
    // Only the way named by fifo is written and the other way is read
    for (int w = 0; w < NUM_WAYS; w++)
      if ((s.refill.fifo == w[0]) && (s.refill.first || s.refill.last))
        sh_tag[w][ix] = e;
      else
        q_tag[w] = sh_tag[w][ix];
    if (s.refill.last)
      sh_fifo[ix] = ~s.refill.fifo;
    else
      q_fifo = sh_fifo[ix];
    sh_data[s.refill.fifo][ix] = {s.refill.inst, s.refill.precode};
  end
  else if (look_a)
  begin
    ix = s.ipb.valid ? s.ipb.index : s.fetch.index;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      q_tag[w] = sh_tag[w][ix];
      if (!s.ipb.valid && s.fetch.way_pred[w])
        q_data[w] = sh_data[w][ix];
    end
    q_fifo = sh_fifo[ix];
  end
  if (s.icache_en && s.cnt_en)
  begin
    q_acc  = s.fetch.valid;
    q_miss = s.miss_pre;
  end
endtask

task automatic add_row(input string name, input logic chk, input stim_t s);
  expect_t e;
  model_step(s);
  e = {q_fifo, q_tag[1], q_tag[0], q_data[0], q_data[1], q_acc, q_miss};
  stim_q.push_back(s);
  exp_q.push_back(e);
  chk_q.push_back(chk);
  name_q.push_back(name);
endtask

//======================================================================
// Row builders
//======================================================================
function automatic stim_t idle_stim();
  stim_t s;
  s = '0;
  s.icache_en = 1'b1;
  s.cnt_en    = 1'b1;
  return s;
endfunction

function automatic stim_t fetch_stim(input index_t ix, input logic [1:0] pred);
  stim_t s;
  s = idle_stim();
  s.fetch = {1'b1, ix, pred};
  return s;
endfunction

function automatic stim_t ipb_stim(input index_t ix);
  stim_t s;
  s = idle_stim();
  s.ipb = {1'b1, ix};
  return s;
endfunction

// first_last is {first, last} and beat data comes from the LFSR
function automatic stim_t refill_beat(input index_t ix, input logic fifo,
                                      input logic [1:0] first_last,
                                      input logic [TAG_W-1:0] ptag);
  stim_t s;
  s = idle_stim();
  s.refill.wr    = 1'b1;
  s.refill.first = first_last[1];
  s.refill.last  = first_last[0];
  s.refill.fifo  = fifo;
  s.refill.index = ix;
  s.refill.ptag  = ptag;
  s.refill.inst    = lfsr_bits(INST_W);
  s.refill.precode = PRECODE_W'(lfsr_bits(PRECODE_W));
  return s;
endfunction

task automatic build_table();
  stim_t            s;
  logic [TAG_W-1:0] ptag_a;
  logic [TAG_W-1:0] ptag_b;
  logic [127:0]     r;
  s = idle_stim();
  s.icache_en = 1'b0;
  add_row("reset_idle", 1'b1, s);
  // Fill way 0 of set 0x15, then read it back
  ptag_a = TAG_W'(lfsr_bits(TAG_W));
  add_row("fill0_first", 1'b1, refill_beat(6'h15, 1'b0, 2'b10, ptag_a));
  add_row("fill0_mid", 1'b0, refill_beat(6'h15, 1'b0, 2'b00, ptag_a));
  add_row("fill0_mid", 1'b0, refill_beat(6'h15, 1'b0, 2'b00, ptag_a));
  add_row("fill0_last", 1'b1, refill_beat(6'h15, 1'b0, 2'b01, ptag_a));
  add_row("fetch_way0", 1'b1, fetch_stim(6'h15, 2'b01));
  // Second refill follows the flipped fifo bit into way 1
  ptag_b = TAG_W'(lfsr_bits(TAG_W));
  add_row("fill1_first", 1'b1, refill_beat(6'h15, 1'b1, 2'b10, ptag_b));
  add_row("fill1_mid", 1'b0, refill_beat(6'h15, 1'b1, 2'b00, ptag_b));
  add_row("fill1_last", 1'b1, refill_beat(6'h15, 1'b1, 2'b01, ptag_b));
  add_row("fetch_both", 1'b1, fetch_stim(6'h15, 2'b11));
  // Refill wins over ipb and fetch to other sets
  s = refill_beat(6'h2a, 1'b0, 2'b10, ptag_a);
  s.ipb   = {1'b1, 6'h07};
  s.fetch = {1'b1, 6'h31, 2'b11};
  add_row("prio_first", 1'b1, s);
  s.refill.first = 1'b0;
  s.refill.last  = 1'b1;
  add_row("prio_last", 1'b1, s);
  add_row("prio_hold", 1'b1, idle_stim());
  add_row("prio_ipb_lookup", 1'b1, ipb_stim(6'h2a));
  // Invalidate runs with the cache off while refill and fetch do not
  s = refill_beat(6'h15, 1'b1, 2'b10, ptag_b);
  s.fetch     = {1'b1, 6'h15, 2'b11};
  s.inv       = {1'b1, 6'h15, 3'b101, 1'b1};
  s.icache_en = 1'b0;
  add_row("inv_way0_off", 1'b1, s);
  s.inv          = '0;
  s.refill.first = 1'b0;
  s.refill.last  = 1'b1;
  add_row("off_ignored", 1'b1, s);
  add_row("inv_lookup", 1'b1, ipb_stim(6'h15));
  add_row("inv_keeps_data", 1'b1, fetch_stim(6'h15, 2'b11));
  // Random event patterns with counting or the cache sometimes off
  for (int k = 0; k < 12; k++)
  begin
    r = lfsr_bits(4);
    s = fetch_stim(6'h31, 2'b00);
    s.fetch.valid = r[0];
    s.miss_pre    = r[1];
    s.cnt_en      = r[2];
    s.icache_en   = r[3];
    add_row($sformatf("events_%0d", k), 1'b1, s);
  end
endtask

`endif

/* tests/tb_icache_if.sv */
/*
  Testbench for the instruction cache access port
  Applies the stimulus table row by row and checks each flagged row
  one cycle later against the reference model
*/

`timescale 1ns/10ps

module tb_icache_if;

  import icache_pkg::*;

  logic        hpcp_clk;
  logic        cpurst_b;
  inv_req_t    inv_req;
  refill_req_t refill_req;
  ipb_req_t    ipb_req;
  fetch_req_t  fetch_req;
  logic        icache_en;
  logic        cnt_en;
  logic        miss_pre;
  tag_dout_t   tag_dout;
  line_t       data_dout0;
  line_t       data_dout1;
  logic        hpcp_access;
  logic        hpcp_miss;
  logic [31:0] lfsr_state = 32'h64e2;
  int          cycle_cnt = 0;
  int          cycle_limit = 1000;
  int          err_cnt = 0;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [127:0] lfsr_bits(input int nbits);
    logic [127:0] v;
    logic         lsb;
    v = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      v = {v[126:0], lsb};
    end
    return v;
  endfunction

  `include "tb_icache_table.svh"

  icache_if u_icache_if (
    .hpcp_clk    (hpcp_clk),
    .cpurst_b    (cpurst_b),
    .inv_req     (inv_req),
    .refill_req  (refill_req),
    .ipb_req     (ipb_req),
    .fetch_req   (fetch_req),
    .icache_en   (icache_en),
    .cnt_en      (cnt_en),
    .miss_pre    (miss_pre),
    .tag_dout    (tag_dout),
    .data_dout0  (data_dout0),
    .data_dout1  (data_dout1),
    .hpcp_access (hpcp_access),
    .hpcp_miss   (hpcp_miss)
  );

  initial
  begin
    hpcp_clk = 1'b0;
    forever #4 hpcp_clk = ~hpcp_clk;
  end

  task automatic check_value(input string what, input expect_t exp, input expect_t act);
    if (act !== exp)
    begin
      err_cnt++;
      $display("Fail %s expected %h actual %h", what, exp, act);
      $display("Checks failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  //======================================================================
  // Cycle limit
  //======================================================================
  always @(posedge hpcp_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      $display("Checks failed");
      $fatal(1, "Stopped by the cycle limit");
    end
  end

  //======================================================================
  // Stimulus and checks
  //======================================================================
  initial
  begin
    cpurst_b   = 1'b0;
    inv_req    = '0;
    refill_req = '0;
    ipb_req    = '0;
    fetch_req  = '0;
    icache_en  = 1'b0;
    cnt_en     = 1'b0;
    miss_pre   = 1'b0;
    build_table();
    cycle_limit = 2 * stim_q.size() + 50;
    repeat (10) @(posedge hpcp_clk);
    #1;
    cpurst_b = 1'b1;
    // Row i goes in 1 ns after an edge, its result is sampled after the next one
    for (int i = 0; i < stim_q.size(); i++)
    begin
      {inv_req, refill_req, ipb_req, fetch_req, icache_en, cnt_en, miss_pre} = stim_q[i];
      @(posedge hpcp_clk);
      #1;
      if (chk_q[i])
        check_value(name_q[i], exp_q[i],
                    {tag_dout, data_dout0, data_dout1, hpcp_access, hpcp_miss});
    end
    if (err_cnt == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      $display("Checks failed");
      $fatal(1, "Mismatches were found");
    end
  end

endmodule

/* files.f */
+incdir+tests
source/icache_pkg.sv
source/icache_sram.sv
source/icache_index_arb.sv
source/icache_tag_ctrl.sv
source/icache_data_ctrl.sv
source/icache_if.sv
tests/tb_icache_if.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, then look for the pass line in the log
rm -rf obj_dir sim.log &&
verilator --binary -f files.f --top-module tb_icache_if -o tb_icache_if > build.log 2>&1 &&
./obj_dir/tb_icache_if > sim.log 2>&1
grep -qx "All checks passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
